// ==== rtl/atc_msg_pkg.sv ====
/*
  Message word format shared by the controller and its testbench.
  A word carries a plane id, a message type and a two-bit action.
*/
package atc_msg_pkg;

  localparam int PLANE_ID_WIDTH = 4;
  localparam int TYPE_WIDTH     = 3;
  localparam int ACTION_WIDTH   = 2;
  localparam int MSG_WIDTH      = PLANE_ID_WIDTH + TYPE_WIDTH + ACTION_WIDTH;

  typedef logic [PLANE_ID_WIDTH-1:0] plane_id_t;
  typedef logic [ACTION_WIDTH-1:0]   msg_action_t;

  // Inbound codes 0 to 2, reply codes 4 to 7
  typedef enum logic [TYPE_WIDTH-1:0] {
    T_REQUEST   = 0,
    T_DECLARE   = 1,
    T_EMERGENCY = 2,
    T_CLEAR     = 4,
    T_HOLD      = 5,
    T_SAY_AGAIN = 6,
    T_DIVERT    = 7
  } msg_type_t;

  typedef struct packed {
    plane_id_t   plane_id;
    msg_type_t   msg_type;
    msg_action_t msg_action;
  } msg_t;

  // Action field meanings
  localparam int          ACT_LANDING_BIT       = 1;
  localparam int          ACT_RUNWAY_BIT        = 0;
  localparam msg_action_t ACT_EMERGENCY_SET     = 2'b01;
  localparam msg_action_t ACT_EMERGENCY_RESOLVE = 2'b00;

endpackage

// ==== rtl/atc_ctrl_pkg.sv ====
/*
  Controller state definitions: queue sizes, runway encoding,
  interpreter states and the reply kinds handed to the reply builder.
*/
package atc_ctrl_pkg;

  localparam int RUNWAY_COUNT = 2;
  localparam int QUEUE_DEPTH  = 4;

  typedef logic [RUNWAY_COUNT-1:0]         runway_mask_t;
  typedef logic [$clog2(RUNWAY_COUNT)-1:0] runway_id_t;

  typedef enum logic [2:0] {
    R_NONE, R_HOLD, R_SAY_AGAIN, R_DIVERT,
    R_CLEAR_TAKEOFF, R_CLEAR_LANDING, R_DIVERT_LANDING
  } reply_kind_t;

  typedef enum logic [2:0] {
    QUIET, INTERPRET, REPLY, CHECK_QUEUES,
    CLR_TAKEOFF, CLR_LANDING, DIVERT_LANDING, QUEUE_CLR
  } request_state_t;

endpackage

// ==== rtl/atc_fifo.sv ====
/*
  Show-ahead FIFO. The head word is on data_out whenever empty is low;
  pop advances it on the clock edge. A push while full is dropped.
*/
module atc_fifo #(
  parameter int WIDTH = 9,
  parameter int DEPTH = 4
) (
  input  logic             clock,
  input  logic             reset,
  input  logic [WIDTH-1:0] data_in,
  input  logic             push,
  input  logic             pop,
  output logic [WIDTH-1:0] data_out,
  output logic             full,
  output logic             empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty    = (count == '0);
  assign full     = (count == CNT_W'(DEPTH));
  assign data_out = mem[rd_ptr];
  assign do_pop   = pop && !empty;
  assign do_push  = push && !full;

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      count  <= '0;
      rd_ptr <= '0;
      wr_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Consumers only pop a queue whose head they have seen valid
  assert property (@(posedge clock) disable iff (reset) pop |-> !empty)
    else $error("pop on empty queue");

endmodule

// ==== rtl/atc_request_fsm.sv ====
/*
  Request interpreter. Takes one word at a time from the intake queue,
  files planes into the takeoff and landing queues, keeps the emergency
  latch and clears queued planes onto free runways.
*/
module atc_request_fsm
  import atc_msg_pkg::*, atc_ctrl_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  msg_t         request,
  input  logic         request_empty,
  input  logic         takeoff_full,
  input  logic         takeoff_empty,
  input  logic         landing_full,
  input  logic         landing_empty,
  input  logic         reply_full,
  input  runway_mask_t runway_active,
  output logic         request_pop,
  output logic         takeoff_push,
  output logic         takeoff_pop,
  output logic         landing_push,
  output logic         landing_pop,
  output reply_kind_t  reply_kind,
  output logic         reply_push,
  output logic         lock,
  output logic         unlock,
  output runway_id_t   runway_id
);

  request_state_t state;
  request_state_t next_state;
  logic           emergency;
  logic           emergency_set;
  logic           emergency_clear;
  logic           takeoff_first;
  logic           takeoff_first_next;
  logic           runway_free;
  runway_id_t     free_runway;

  assign runway_free = ~&runway_active;

  // Lowest numbered runway not in use
  always_comb begin
    free_runway = '0;
    for (int i = RUNWAY_COUNT - 1; i >= 0; i--) begin
      if (!runway_active[i]) begin
        free_runway = runway_id_t'(i);
      end
    end
  end

  always_comb begin
    next_state         = state;
    request_pop        = 1'b0;
    takeoff_push       = 1'b0;
    takeoff_pop        = 1'b0;
    landing_push       = 1'b0;
    landing_pop        = 1'b0;
    reply_kind         = R_NONE;
    reply_push         = 1'b0;
    lock               = 1'b0;
    unlock             = 1'b0;
    runway_id          = '0;
    emergency_set      = 1'b0;
    emergency_clear    = 1'b0;
    takeoff_first_next = takeoff_first;

    unique case (state)
      QUIET: begin
        next_state = request_empty ? CHECK_QUEUES : INTERPRET;
      end

      //////////////////////////////////////////////////////////////////////////
      // Decide on the head request; it leaves the intake queue this cycle
      //////////////////////////////////////////////////////////////////////////
      INTERPRET: begin
        request_pop = 1'b1;
        next_state  = REPLY;
        case (request.msg_type)
          T_REQUEST: begin
            if (request.msg_action[ACT_LANDING_BIT]) begin
              if (landing_full || emergency) begin
                reply_kind = R_DIVERT;
              end else begin
                landing_push = 1'b1;
                reply_kind   = R_HOLD;
              end
            end else if (takeoff_full) begin
              reply_kind = R_DIVERT;
            end else begin
              takeoff_push = 1'b1;
              reply_kind   = R_HOLD;
            end
          end
          T_DECLARE: begin
            // No reply; the runway manager checks ownership
            unlock     = 1'b1;
            runway_id  = runway_id_t'(request.msg_action[ACT_RUNWAY_BIT]);
            next_state = CHECK_QUEUES;
          end
          T_EMERGENCY: begin
            emergency_set   = (request.msg_action == ACT_EMERGENCY_SET);
            emergency_clear = (request.msg_action == ACT_EMERGENCY_RESOLVE);
            next_state      = CHECK_QUEUES;
          end
          default: begin
            reply_kind = R_SAY_AGAIN;
          end
        endcase
      end

      REPLY: begin
        if (!reply_full) begin
          reply_push = 1'b1;
          next_state = CHECK_QUEUES;
        end
      end

      //////////////////////////////////////////////////////////////////////////
      // Serve the waiting queues, one plane per pass
      //////////////////////////////////////////////////////////////////////////
      CHECK_QUEUES: begin
        next_state = QUIET;
        if (emergency) begin
          if (!landing_empty) begin
            landing_pop = 1'b1;
            reply_kind  = R_DIVERT_LANDING;
            next_state  = DIVERT_LANDING;
          end
        end else if (runway_free) begin
          runway_id = free_runway;
          if (!takeoff_empty && (takeoff_first || landing_empty)) begin
            takeoff_pop        = 1'b1;
            reply_kind         = R_CLEAR_TAKEOFF;
            takeoff_first_next = 1'b0;
            next_state         = CLR_TAKEOFF;
          end else if (!landing_empty) begin
            landing_pop        = 1'b1;
            reply_kind         = R_CLEAR_LANDING;
            takeoff_first_next = 1'b1;
            next_state         = CLR_LANDING;
          end
        end
      end

      // Clear word is now registered, so its plane id becomes the owner
      CLR_TAKEOFF, CLR_LANDING: begin
        lock       = 1'b1;
        runway_id  = free_runway;
        next_state = QUEUE_CLR;
      end

      DIVERT_LANDING: begin
        next_state = QUEUE_CLR;
      end

      QUEUE_CLR: begin
        if (!reply_full) begin
          reply_push = 1'b1;
          next_state = QUIET;
        end
      end

      default: begin
        next_state = QUIET;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= QUIET;
      emergency     <= 1'b0;
      takeoff_first <= 1'b1;
    end else begin
      state         <= next_state;
      takeoff_first <= takeoff_first_next;
      if (emergency_set) begin
        emergency <= 1'b1;
      end else if (emergency_clear) begin
        emergency <= 1'b0;
      end
    end
  end

  assert property (@(posedge clock) disable iff (reset) !(lock && unlock))
    else $error("runway lock and unlock in the same cycle");

endmodule

// ==== rtl/atc_reply_builder.sv ====
/*
  Reply word register. Composes the next reply from the kind chosen by the
  interpreter; the word waits here until the interpreter queues it.
*/
module atc_reply_builder
  import atc_msg_pkg::*, atc_ctrl_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  reply_kind_t reply_kind,
  input  msg_t        request,
  input  plane_id_t   takeoff_head,
  input  plane_id_t   landing_head,
  input  runway_id_t  runway_id,
  output msg_t        reply
);

  always_ff @(posedge clock) begin
    if (reset) begin
      reply <= '0;
    end else begin
      unique case (reply_kind)
        R_NONE:      reply <= reply;
        R_HOLD:      reply <= '{request.plane_id, T_HOLD, '0};
        R_SAY_AGAIN: reply <= '{request.plane_id, T_SAY_AGAIN, '0};
        R_DIVERT:    reply <= '{request.plane_id, T_DIVERT, '0};
        // Clears carry the granted runway in the action field
        R_CLEAR_TAKEOFF: begin
          reply <= '{takeoff_head, T_CLEAR, msg_action_t'(runway_id)};
        end
        R_CLEAR_LANDING: begin
          reply <= '{landing_head, T_CLEAR, msg_action_t'(runway_id)};
        end
        R_DIVERT_LANDING: begin
          reply <= '{landing_head, T_DIVERT, '0};
        end
        default: reply <= reply;
      endcase
    end
  end

endmodule

// ==== rtl/atc_runway_manager.sv ====
/*
  Runway lock table. Each runway records the plane holding it; only that
  plane's declare releases the runway again.
*/
module atc_runway_manager
  import atc_msg_pkg::*, atc_ctrl_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  plane_id_t    plane_id,
  input  runway_id_t   runway_id,
  input  logic         lock,
  input  logic         unlock,
  output runway_mask_t runway_active
);

  plane_id_t owner [RUNWAY_COUNT];

  always_ff @(posedge clock) begin
    if (lock) begin
      owner[runway_id] <= plane_id;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      runway_active <= '0;
    end else if (lock) begin
      runway_active[runway_id] <= 1'b1;
    end else if (unlock && (owner[runway_id] == plane_id)) begin
      // Declares from any other plane are ignored
      runway_active[runway_id] <= 1'b0;
    end
  end

  // The interpreter only clears onto a runway it saw free
  assert property (@(posedge clock) disable iff (reset) lock |-> !runway_active[runway_id])
    else $error("lock on a runway already in use");

endmodule

// ==== rtl/atc_reply_sender.sv ====
/*
  Drains the reply queue toward the transmitter. One word per visit:
  pop while the transmitter is ready, then strobe the word out.
*/
module atc_reply_sender
  import atc_msg_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic reply_empty,
  input  logic tx_ready,
  input  msg_t reply_head,
  output logic reply_pop,
  output msg_t reply_data,
  output logic reply_send
);

  typedef enum logic {S_WAIT, S_SEND} sender_state_t;

  sender_state_t state;

  assign reply_pop  = (state == S_WAIT) && !reply_empty && tx_ready;
  assign reply_send = (state == S_SEND);

  // Held until the next word is popped
  always_ff @(posedge clock) begin
    if (reply_pop) begin
      reply_data <= reply_head;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= S_WAIT;
    end else begin
      state <= reply_pop ? S_SEND : S_WAIT;
    end
  end

endmodule

// ==== rtl/atc_controller.sv ====
/*
  Two-runway message controller top level. Request words enter with
  request_valid; replies leave on reply_data, marked by reply_send.
*/
module atc_controller
  import atc_msg_pkg::*, atc_ctrl_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  msg_t         request_data,
  input  logic         request_valid,
  output logic         busy,
  output msg_t         reply_data,
  output logic         reply_send,
  input  logic         tx_ready,
  output runway_mask_t runway_active
);

  msg_t        request, reply, reply_head;
  plane_id_t   takeoff_head, landing_head, runway_plane_id;
  logic        request_pop, request_empty;
  logic        takeoff_push, takeoff_pop, takeoff_full, takeoff_empty;
  logic        landing_push, landing_pop, landing_full, landing_empty;
  logic        reply_push, reply_pop, reply_full, reply_empty;
  logic        lock, unlock;
  reply_kind_t reply_kind;
  runway_id_t  runway_id;

  // Owner on lock comes from the registered clear, on unlock from the declare
  assign runway_plane_id = lock ? reply.plane_id : request.plane_id;

  ////////////////////////////////////////////////////////////////////////////
  // Queues
  ////////////////////////////////////////////////////////////////////////////
  atc_fifo #(.WIDTH(MSG_WIDTH), .DEPTH(QUEUE_DEPTH)) u_request_fifo (
    .clock, .reset, .data_in(request_data), .push(request_valid), .pop(request_pop),
    .data_out(request), .full(busy), .empty(request_empty)
  );

  atc_fifo #(.WIDTH(PLANE_ID_WIDTH), .DEPTH(QUEUE_DEPTH)) u_takeoff_fifo (
    .clock, .reset, .data_in(request.plane_id), .push(takeoff_push), .pop(takeoff_pop),
    .data_out(takeoff_head), .full(takeoff_full), .empty(takeoff_empty)
  );

  atc_fifo #(.WIDTH(PLANE_ID_WIDTH), .DEPTH(QUEUE_DEPTH)) u_landing_fifo (
    .clock, .reset, .data_in(request.plane_id), .push(landing_push), .pop(landing_pop),
    .data_out(landing_head), .full(landing_full), .empty(landing_empty)
  );

  atc_fifo #(.WIDTH(MSG_WIDTH), .DEPTH(QUEUE_DEPTH)) u_reply_fifo (
    .clock, .reset, .data_in(reply), .push(reply_push), .pop(reply_pop),
    .data_out(reply_head), .full(reply_full), .empty(reply_empty)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Interpreter, reply path and runway locks
  ////////////////////////////////////////////////////////////////////////////
  atc_request_fsm u_request_fsm (
    .clock, .reset, .request, .request_empty, .takeoff_full, .takeoff_empty,
    .landing_full, .landing_empty, .reply_full, .runway_active, .request_pop,
    .takeoff_push, .takeoff_pop, .landing_push, .landing_pop, .reply_kind,
    .reply_push, .lock, .unlock, .runway_id
  );

  atc_reply_builder u_reply_builder (
    .clock, .reset, .reply_kind, .request, .takeoff_head, .landing_head,
    .runway_id, .reply
  );

  atc_runway_manager u_runway_manager (
    .clock, .reset, .plane_id(runway_plane_id), .runway_id, .lock, .unlock,
    .runway_active
  );

  atc_reply_sender u_reply_sender (
    .clock, .reset, .reply_empty, .tx_ready, .reply_head, .reply_pop,
    .reply_data, .reply_send
  );

endmodule

// ==== sim/tb_atc_controller.sv ====
/*
  Directed testbench for the two-runway message controller.
  Sends request words, collects replies on reply_send in order and
  checks reply words, runway locks and the busy flag. Run through the Makefile.
*/
module tb_atc_controller
  import atc_msg_pkg::*, atc_ctrl_pkg::*;
;

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int WATCH_CYCLES   = 40;

  logic         clock;
  logic         reset;
  msg_t         request_data;
  logic         request_valid;
  logic         busy;
  msg_t         reply_data;
  logic         reply_send;
  logic         tx_ready;
  runway_mask_t runway_active;
  int           cycle_count;

  atc_controller u_atc_controller (
    .clock, .reset, .request_data, .request_valid, .busy, .reply_data,
    .reply_send, .tx_ready, .runway_active
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clock);
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("Timeout after %0d cycles, a reply never arrived", cycle_count);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and reply helpers
  ////////////////////////////////////////////////////////////////////////////
  // Raw type code, so that invalid codes can be sent too
  function automatic msg_t make_word(input plane_id_t id, input logic [2:0] code,
                                     input msg_action_t act);
    msg_t w;
    w.plane_id   = id;
    w.msg_type   = msg_type_t'(code);
    w.msg_action = act;
    return w;
  endfunction

  task automatic send_word(input msg_t w);
    @(posedge clock);
    #1;
    request_data  = w;
    request_valid = 1'b1;
    @(posedge clock);
    #1;
    request_valid = 1'b0;
  endtask

  // Sampled on the falling edge, where reply_send and reply_data are settled
  task automatic get_reply(output msg_t w);
    do begin
      @(negedge clock);
    end while (!reply_send);
    w = reply_data;
  endtask

  task automatic check_msg(input string name, input msg_t expected, input msg_t actual);
    if (actual !== expected) begin
      $display("Error %s: expected %h actual %h", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "reply mismatch");
    end
  endtask

  task automatic check_runways(input string name, input runway_mask_t expected,
                               input runway_mask_t actual);
    if (actual !== expected) begin
      $display("Error %s: expected %b actual %b", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "runway mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error %s: expected %b actual %b", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic expect_reply(input string name, input plane_id_t id,
                              input msg_type_t t, input msg_action_t act);
    msg_t w;
    get_reply(w);
    check_msg(name, make_word(id, t, act), w);
  endtask

  // Invalid word as an ordering marker; its reply proves earlier words were handled
  task automatic sync_marker(input string name);
    send_word(make_word(4'hf, 3'd3, 2'b00));
    expect_reply(name, 4'hf, T_SAY_AGAIN, 2'b00);
  endtask

  task automatic watch_no_send(input string name);
    repeat (WATCH_CYCLES) begin
      @(negedge clock);
      if (reply_send) begin
        $display("%s: a reply went out while the transmitter was not ready", name);
        $display("TESTBENCH FAILED");
        $fatal(1, "unexpected reply_send");
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic test_invalid_type();
    send_word(make_word(4'd6, 3'd5, 2'b00));
    expect_reply("invalid_type", 4'd6, T_SAY_AGAIN, 2'b00);
    check_runways("invalid_type", 2'b00, runway_active);
  endtask

  task automatic test_takeoff_flow();
    send_word(make_word(4'd3, T_REQUEST, 2'b00));
    expect_reply("takeoff_flow hold 3", 4'd3, T_HOLD, 2'b00);
    expect_reply("takeoff_flow clear 3", 4'd3, T_CLEAR, 2'b00);
    check_runways("takeoff_flow lock 0", 2'b01, runway_active);
    send_word(make_word(4'd7, T_REQUEST, 2'b00));
    expect_reply("takeoff_flow hold 7", 4'd7, T_HOLD, 2'b00);
    expect_reply("takeoff_flow clear 7", 4'd7, T_CLEAR, 2'b01);
    check_runways("takeoff_flow lock 1", 2'b11, runway_active);
    // Plane 9 does not own runway 0
    send_word(make_word(4'd9, T_DECLARE, 2'b00));
    sync_marker("takeoff_flow marker 9");
    check_runways("takeoff_flow foreign declare", 2'b11, runway_active);
    send_word(make_word(4'd3, T_DECLARE, 2'b00));
    sync_marker("takeoff_flow marker 3");
    check_runways("takeoff_flow owner declare", 2'b10, runway_active);
  endtask

  task automatic test_queue_limits();
    plane_id_t ids [4] = '{4'd2, 4'd4, 4'd5, 4'd6};
    send_word(make_word(4'd1, T_REQUEST, 2'b00));
    expect_reply("queue_limits hold 1", 4'd1, T_HOLD, 2'b00);
    expect_reply("queue_limits clear 1", 4'd1, T_CLEAR, 2'b00);
    check_runways("queue_limits both locked", 2'b11, runway_active);
    foreach (ids[i]) begin
      send_word(make_word(ids[i], T_REQUEST, 2'b00));
      expect_reply("queue_limits hold", ids[i], T_HOLD, 2'b00);
    end
    send_word(make_word(4'd8, T_REQUEST, 2'b00));
    expect_reply("queue_limits divert 8", 4'd8, T_DIVERT, 2'b00);
    send_word(make_word(4'd7, T_DECLARE, 2'b01));
    expect_reply("queue_limits clear 2", 4'd2, T_CLEAR, 2'b01);
    sync_marker("queue_limits single clear");
    check_runways("queue_limits relocked", 2'b11, runway_active);
  endtask

  task automatic test_emergency();
    send_word(make_word(4'd10, T_REQUEST, 2'b10));
    expect_reply("emergency hold 10", 4'd10, T_HOLD, 2'b00);
    send_word(make_word(4'd11, T_REQUEST, 2'b10));
    expect_reply("emergency hold 11", 4'd11, T_HOLD, 2'b00);
    send_word(make_word(4'd0, T_EMERGENCY, ACT_EMERGENCY_SET));
    expect_reply("emergency divert 10", 4'd10, T_DIVERT, 2'b00);
    expect_reply("emergency divert 11", 4'd11, T_DIVERT, 2'b00);
    send_word(make_word(4'd12, T_REQUEST, 2'b10));
    expect_reply("emergency divert 12", 4'd12, T_DIVERT, 2'b00);
    // Runway 0 frees up, but nothing may be cleared yet
    send_word(make_word(4'd1, T_DECLARE, 2'b00));
    sync_marker("emergency no clear");
    check_runways("emergency free 0", 2'b10, runway_active);
    send_word(make_word(4'd0, T_EMERGENCY, ACT_EMERGENCY_RESOLVE));
    expect_reply("emergency clear 4", 4'd4, T_CLEAR, 2'b00);
    check_runways("emergency resolved", 2'b11, runway_active);
  endtask

  task automatic test_back_pressure();
    @(posedge clock);
    #1;
    tx_ready = 1'b0;
    send_word(make_word(4'd13, 3'd3, 2'b00));
    send_word(make_word(4'd14, 3'd3, 2'b00));
    send_word(make_word(4'd15, 3'd3, 2'b00));
    watch_no_send("back_pressure");
    @(posedge clock);
    #1;
    tx_ready = 1'b1;
    expect_reply("back_pressure 13", 4'd13, T_SAY_AGAIN, 2'b00);
    expect_reply("back_pressure 14", 4'd14, T_SAY_AGAIN, 2'b00);
    expect_reply("back_pressure 15", 4'd15, T_SAY_AGAIN, 2'b00);
  endtask

  // Four words fill the reply queue, one more stalls the interpreter,
  // four after that fill the intake queue and the tenth is lost
  task automatic test_busy();
    @(posedge clock);
    #1;
    tx_ready = 1'b0;
    for (int i = 0; i < 4; i++) begin
      send_word(make_word(plane_id_t'(i), 3'd3, 2'b00));
    end
    watch_no_send("busy reply queue full");
    check_flag("busy idle", 1'b0, busy);
    for (int i = 4; i < 9; i++) begin
      send_word(make_word(plane_id_t'(i), 3'd3, 2'b00));
    end
    check_flag("busy intake full", 1'b1, busy);
    send_word(make_word(4'd9, 3'd3, 2'b00));
    @(posedge clock);
    #1;
    tx_ready = 1'b1;
    for (int i = 0; i < 9; i++) begin
      expect_reply("busy drain", plane_id_t'(i), T_SAY_AGAIN, 2'b00);
    end
    check_flag("busy released", 1'b0, busy);
    sync_marker("busy lost word");
  endtask

  initial begin
    reset         = 1'b1;
    request_data  = '0;
    request_valid = 1'b0;
    tx_ready      = 1'b1;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    check_runways("reset", 2'b00, runway_active);
    check_flag("reset busy", 1'b0, busy);

    test_invalid_type();
    test_takeoff_flow();
    test_queue_limits();
    test_emergency();
    test_back_pressure();
    test_busy();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== project.f ====
rtl/atc_msg_pkg.sv
rtl/atc_ctrl_pkg.sv
rtl/atc_fifo.sv
rtl/atc_request_fsm.sv
rtl/atc_reply_builder.sv
rtl/atc_runway_manager.sv
rtl/atc_reply_sender.sv
rtl/atc_controller.sv
sim/tb_atc_controller.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_atc_controller
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = TESTBENCH PASSED

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
